// ==== all.f ====
+incdir+.
rv64_decode_pkg.sv
rv64_opcode_match.sv
rv64_operand_extract.sv
rv64_decoder_top.sv
rv64_decoder_tb.sv

// ==== Bender.yml ====
package:
  name: rv64_decoder

sources:
  - rv64_decode_pkg.sv
  - rv64_opcode_match.sv
  - rv64_operand_extract.sv
  - rv64_decoder_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv64_decoder_tb.sv

// ==== rv64_decoder_vectors.svh ====
// Decode table for the RV64IM decoder testbench, included inside the testbench module
// Columns: word, function, uses {rd, rs1, rs2}, rd, rs1, rs2, immediate, jump

task automatic load_table;
  ////////////////////
  // Base ALU
  ////////////////////
  add_row({7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'h33}, F_ADD, 3'b111, 1, 2, 3, 0, 0);
  add_row({7'h20, 5'd12, 5'd11, 3'b000, 5'd10, 7'h33}, F_SUB, 3'b111, 10, 11, 12, 0, 0);
  add_row({7'h00, 5'd31, 5'd0, 3'b010, 5'd5, 7'h33}, F_SLT, 3'b111, 5, 0, 31, 0, 0);  // x0 named
  add_row({7'h00, 5'd29, 5'd30, 3'b100, 5'd31, 7'h33}, F_XOR, 3'b111, 31, 30, 29, 0, 0);
  add_row({7'h20, 5'd11, 5'd10, 3'b101, 5'd9, 7'h33}, F_SRA, 3'b111, 9, 10, 11, 0, 0);
  add_row({7'h00, 5'd14, 5'd13, 3'b110, 5'd12, 7'h33}, F_OR, 3'b111, 12, 13, 14, 0, 0);
  add_row({7'h00, 5'd17, 5'd16, 3'b111, 5'd15, 7'h33}, F_AND, 3'b111, 15, 16, 17, 0, 0);
  add_row({12'hFFF, 5'd8, 3'b110, 5'd7, 7'h13}, F_ORI, 3'b110, 7, 8, 0, -1, 0);
  add_row({12'h7FF, 5'd0, 3'b000, 5'd0, 7'h13}, F_ADDI, 3'b110, 0, 0, 0, 2047, 0);
  add_row({12'h800, 5'd4, 3'b010, 5'd3, 7'h13}, F_SLTI, 3'b110, 3, 4, 0, -2048, 0);
  add_row({12'h001, 5'd21, 3'b011, 5'd20, 7'h13}, F_SLTIU, 3'b110, 20, 21, 0, 1, 0);
  add_row({12'hF0F, 5'd25, 3'b111, 5'd24, 7'h13}, F_ANDI, 3'b110, 24, 25, 0, -241, 0);

  // Loads and stores
  add_row({12'h000, 5'd2, 3'b000, 5'd1, 7'h03}, F_LB, 3'b110, 1, 2, 0, 0, 0);
  add_row({12'hFFE, 5'd4, 3'b001, 5'd3, 7'h03}, F_LH, 3'b110, 3, 4, 0, -2, 0);
  add_row({12'hFF8, 5'd8, 3'b011, 5'd7, 7'h03}, F_LD, 3'b110, 7, 8, 0, -8, 0);
  add_row({12'h7FC, 5'd14, 3'b110, 5'd13, 7'h03}, F_LWU, 3'b110, 13, 14, 0, 2044, 0);
  add_row({7'h09, 5'd1, 5'd3, 3'b000, 5'h03, 7'h23}, F_SB, 3'b011, 0, 3, 1, 291, 0);
  add_row({7'h7F, 5'd4, 5'd5, 3'b001, 5'h1F, 7'h23}, F_SH, 3'b011, 0, 5, 4, -1, 0);
  add_row({7'h40, 5'd6, 5'd7, 3'b010, 5'h00, 7'h23}, F_SW, 3'b011, 0, 7, 6, -2048, 0);
  add_row({7'h7F, 5'd5, 5'd2, 3'b011, 5'h18, 7'h23}, F_SD, 3'b011, 0, 2, 5, -8, 0);

  // Upper immediates
  add_row({20'h80000, 5'd5, 7'h37}, F_LUI, 3'b100, 5, 0, 0, 64'hFFFF_FFFF_8000_0000, 0);
  add_row({20'h12345, 5'd6, 7'h17}, F_AUIPC, 3'b100, 6, 0, 0, 64'h0000_0000_1234_5000, 0);
  add_row({20'hFFFFF, 5'd0, 7'h37}, F_LUI, 3'b100, 0, 0, 0, -4096, 0);

  ////////////////////
  // Control transfers
  ////////////////////
  add_row({1'b1, 10'h3FC, 1'b1, 8'hFF, 5'd1, 7'h6F}, F_JAL, 3'b100, 1, 0, 0, -8, 1);
  add_row({1'b0, 10'h26F, 1'b1, 8'hAB, 5'd0, 7'h6F}, F_JAL, 3'b100, 0, 0, 0, 64'hA_BCDE, 1);
  add_row({12'h010, 5'd5, 3'b000, 5'd1, 7'h67}, F_JALR, 3'b110, 1, 5, 0, 16, 1);
  add_row({12'hFFF, 5'd3, 3'b000, 5'd2, 7'h67}, F_JALR, 3'b110, 2, 3, 0, -1, 1);
  add_row({1'b1, 6'h3F, 5'd2, 5'd1, 3'b000, 4'hE, 1'b1, 7'h63},
          F_BEQ, 3'b011, 0, 1, 2, -4, 1);
  add_row({1'b0, 6'h00, 5'd4, 5'd3, 3'b001, 4'h0, 1'b1, 7'h63},
          F_BNE, 3'b011, 0, 3, 4, 2048, 1);
  add_row({1'b0, 6'h00, 5'd6, 5'd5, 3'b100, 4'h8, 1'b0, 7'h63},
          F_BLT, 3'b011, 0, 5, 6, 16, 1);
  add_row({1'b1, 6'h00, 5'd8, 5'd7, 3'b101, 4'h0, 1'b0, 7'h63},
          F_BGE, 3'b011, 0, 7, 8, -4096, 1);
  add_row({1'b0, 6'h03, 5'd10, 5'd9, 3'b110, 4'hF, 1'b0, 7'h63},
          F_BLTU, 3'b011, 0, 9, 10, 126, 1);
  add_row({1'b0, 6'h3F, 5'd0, 5'd0, 3'b111, 4'hF, 1'b1, 7'h63},
          F_BGEU, 3'b011, 0, 0, 0, 4094, 1);

  // Shift amounts and word forms
  add_row({6'h00, 6'd63, 5'd2, 3'b001, 5'd1, 7'h13}, F_SLLI, 3'b110, 1, 2, 0, 63, 0);
  add_row({6'h00, 6'd32, 5'd4, 3'b101, 5'd3, 7'h13}, F_SRLI, 3'b110, 3, 4, 0, 32, 0);
  add_row({6'h10, 6'd33, 5'd6, 3'b101, 5'd5, 7'h13}, F_SRAI, 3'b110, 5, 6, 0, 33, 0);
  add_row({7'h00, 5'd1, 5'd12, 3'b001, 5'd11, 7'h1B}, F_SLLIW, 3'b110, 11, 12, 0, 1, 0);
  add_row({7'h00, 5'd5, 5'd10, 3'b101, 5'd9, 7'h1B}, F_SRLIW, 3'b110, 9, 10, 0, 5, 0);
  add_row({7'h20, 5'd31, 5'd8, 3'b101, 5'd7, 7'h1B}, F_SRAIW, 3'b110, 7, 8, 0, 31, 0);
  add_row({12'hFFB, 5'd2, 3'b000, 5'd1, 7'h1B}, F_ADDIW, 3'b110, 1, 2, 0, -5, 0);
  add_row({7'h00, 5'd5, 5'd4, 3'b000, 5'd3, 7'h3B}, F_ADDW, 3'b111, 3, 4, 5, 0, 0);
  add_row({7'h20, 5'd8, 5'd7, 3'b000, 5'd6, 7'h3B}, F_SUBW, 3'b111, 6, 7, 8, 0, 0);
  add_row({7'h00, 5'd11, 5'd10, 3'b001, 5'd9, 7'h3B}, F_SLLW, 3'b111, 9, 10, 11, 0, 0);
  add_row({7'h00, 5'd14, 5'd13, 3'b101, 5'd12, 7'h3B}, F_SRLW, 3'b111, 12, 13, 14, 0, 0);
  add_row({7'h20, 5'd17, 5'd16, 3'b101, 5'd15, 7'h3B}, F_SRAW, 3'b111, 15, 16, 17, 0, 0);

  ////////////////////
  // M extension
  ////////////////////
  add_row({7'h01, 5'd3, 5'd2, 3'b000, 5'd1, 7'h33}, F_MUL, 3'b111, 1, 2, 3, 0, 0);
  add_row({7'h01, 5'd6, 5'd5, 3'b001, 5'd4, 7'h33}, F_MULH, 3'b111, 4, 5, 6, 0, 0);
  add_row({7'h01, 5'd9, 5'd8, 3'b010, 5'd7, 7'h33}, F_MULHSU, 3'b111, 7, 8, 9, 0, 0);
  add_row({7'h01, 5'd12, 5'd11, 3'b011, 5'd10, 7'h33}, F_MULHU, 3'b111, 10, 11, 12, 0, 0);
  add_row({7'h01, 5'd15, 5'd14, 3'b100, 5'd13, 7'h33}, F_DIV, 3'b111, 13, 14, 15, 0, 0);
  add_row({7'h01, 5'd18, 5'd17, 3'b101, 5'd16, 7'h33}, F_DIVU, 3'b111, 16, 17, 18, 0, 0);
  add_row({7'h01, 5'd21, 5'd20, 3'b110, 5'd19, 7'h33}, F_REM, 3'b111, 19, 20, 21, 0, 0);
  add_row({7'h01, 5'd24, 5'd23, 3'b111, 5'd22, 7'h33}, F_REMU, 3'b111, 22, 23, 24, 0, 0);
  add_row({7'h01, 5'd27, 5'd26, 3'b000, 5'd25, 7'h3B}, F_MULW, 3'b111, 25, 26, 27, 0, 0);
  add_row({7'h01, 5'd30, 5'd29, 3'b100, 5'd28, 7'h3B}, F_DIVW, 3'b111, 28, 29, 30, 0, 0);
  add_row({7'h01, 5'd2, 5'd1, 3'b101, 5'd31, 7'h3B}, F_DIVUW, 3'b111, 31, 1, 2, 0, 0);
  add_row({7'h01, 5'd5, 5'd4, 3'b110, 5'd3, 7'h3B}, F_REMW, 3'b111, 3, 4, 5, 0, 0);
  add_row({7'h01, 5'd7, 5'd0, 3'b111, 5'd6, 7'h3B}, F_REMUW, 3'b111, 6, 0, 7, 0, 0);

  // Environment and ordering
  add_row(32'h0000_0073, F_ECALL, 3'b000, 0, 0, 0, 0, 0);
  add_row(32'h0010_0073, F_EBREAK, 3'b000, 0, 0, 0, 0, 0);
  add_row(32'h0FF0_000F, F_FENCE, 3'b110, 0, 0, 0, 255, 0);  // pred/succ iorw

  ////////////////////
  // Dropped and unknown
  ////////////////////
  add_row({7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'h53}, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);  // FADD.S
  add_row({7'h00, 5'd3, 5'd2, 3'b010, 5'd1, 7'h2F}, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);  // AMOADD.W
  add_row({12'h300, 5'd2, 3'b001, 5'd1, 7'h73}, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);  // CSRRW
  add_row(32'h8330_000F, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);  // FENCE.TSO
  add_row(32'h0100_000F, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);  // PAUSE
  add_row(32'hFFFF_FFFF, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);
  add_row(32'h0000_0000, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);
  add_row(32'hDEAD_BEEB, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);
  add_row({12'h000, 5'd1, 3'b111, 5'd2, 7'h03}, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);
  add_row({6'h10, 6'd3, 5'd1, 3'b001, 5'd1, 7'h13}, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);
endtask

// ==== rv64_decoder_tb.sv ====
// Testbench for the two-stage RV64IM decoder
// Plays the decode table with random idle gaps and checks each result two cycles later

`timescale 1ns/1ps
`default_nettype none

module rv64_decoder_tb;

  import rv64_decode_pkg::*;

  localparam int MAX_ROWS = 128;
  localparam int LATENCY  = 2;  // Edges from drive to visible result

  logic                clk_i;
  logic                arst_n_i;
  logic                valid_i;
  logic [ILEN-1:0]     instr_i;
  logic                valid_o;
  func_t               func_o;
  logic [REG_AW-1:0]   rd_o;
  logic [REG_AW-1:0]   rs1_o;
  logic [REG_AW-1:0]   rs2_o;
  logic [XLEN-1:0]     imm_o;
  logic                jump_o;
  logic [NUM_REGS-1:0] reg_req_o;

  // Decode table, filled by load_table
  logic [ILEN-1:0]     tab_instr [MAX_ROWS];
  func_t               tab_func  [MAX_ROWS];
  logic [2:0]          tab_use   [MAX_ROWS];  // {rd, rs1, rs2}
  logic [REG_AW-1:0]   tab_rd    [MAX_ROWS];
  logic [REG_AW-1:0]   tab_rs1   [MAX_ROWS];
  logic [REG_AW-1:0]   tab_rs2   [MAX_ROWS];
  logic [XLEN-1:0]     tab_imm   [MAX_ROWS];
  logic                tab_jump  [MAX_ROWS];
  int                  num_rows = 0;

  int     pending_row[$];
  int     pending_cycle[$];  // Cycle count when each row was driven
  int     cycles = 0;
  int     cycle_limit = 40;
  int     value_errors = 0;
  int     other_errors = 0;
  int     cur_row = -1;
  integer seed;

  rv64_decoder_top dut0 (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .valid_i   (valid_i),
    .instr_i   (instr_i),
    .valid_o   (valid_o),
    .func_o    (func_o),
    .rd_o      (rd_o),
    .rs1_o     (rs1_o),
    .rs2_o     (rs2_o),
    .imm_o     (imm_o),
    .jump_o    (jump_o),
    .reg_req_o (reg_req_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic add_row(input logic [ILEN-1:0] word, input func_t func,
                         input logic [2:0] uses, input logic [REG_AW-1:0] rd,
                         input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2,
                         input logic [XLEN-1:0] imm, input logic jump);
    tab_instr[num_rows] = word;
    tab_func[num_rows]  = func;
    tab_use[num_rows]   = uses;
    tab_rd[num_rows]    = rd;
    tab_rs1[num_rows]   = rs1;
    tab_rs2[num_rows]   = rs2;
    tab_imm[num_rows]   = imm;
    tab_jump[num_rows]  = jump;
    num_rows++;
  endtask

  // Jumps claim every register, others only what they name
  function automatic logic [NUM_REGS-1:0] expected_req(input int row);
    logic [NUM_REGS-1:0] req;
    req = '0;
    if (tab_jump[row]) begin
      req = '1;
    end else begin
      if (tab_use[row][2]) req[tab_rd[row]] = 1'b1;
      if (tab_use[row][1]) req[tab_rs1[row]] = 1'b1;
      if (tab_use[row][0]) req[tab_rs2[row]] = 1'b1;
    end
    return req;
  endfunction

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] expected);
    if (got !== expected) begin
      $display("ERR t=%0t row %0d %s got %0h expected %0h", $time, cur_row, name, got,
               expected);
      value_errors++;
    end
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Run stopped after %0d cycles with the table unfinished", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    logic [ILEN-1:0] word;
    int              gap;
    int              k;
    int              r;
    int              drain;
    seed     = 32'h64ee_4eda;
    arst_n_i = 1'b0;
    valid_i  = 1'b0;
    instr_i  = '0;
    load_table();
    // Random words with the low opcode bits not 11 lie outside the 32-bit space
    for (k = 0; k < 6; k++) begin
      word      = $random(seed);
      word[1:0] = 2'(k % 3);
      add_row(word, F_ILLEGAL, 3'b000, 0, 0, 0, 0, 0);
    end
    cycle_limit = num_rows * 3 + 40;

    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check("valid_o", valid_o, 0);
    check("func_o", func_o, F_ILLEGAL);
    repeat (2) @(posedge clk_i);  // Idle, monitor flags any strobe

    for (r = 0; r < num_rows; r++) begin
      @(posedge clk_i);
      #1;
      valid_i = 1'b1;
      instr_i = tab_instr[r];
      pending_row.push_back(r);
      pending_cycle.push_back(cycles);
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        instr_i = $random(seed);  // Must be ignored
      end
    end
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;

    drain = 0;
    while (pending_row.size() != 0 && drain < 2 * LATENCY + 4) begin
      @(posedge clk_i);
      drain++;
    end
    repeat (3) @(posedge clk_i);
    if (pending_row.size() != 0) begin
      $display("%0d instructions never produced a result", pending_row.size());
      other_errors++;
    end
    $display("Checked %0d rows, %0d value errors, %0d other errors", num_rows,
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk_i) begin : compare
    int row;
    int sent;
    if (arst_n_i && valid_o) begin
      if (pending_row.size() == 0) begin
        $display("Result strobe at %0t with no instruction in flight", $time);
        other_errors++;
      end else begin
        row     = pending_row.pop_front();
        sent    = pending_cycle.pop_front();
        cur_row = row;
        check("latency", cycles - sent, LATENCY);
        check("func_o", func_o, tab_func[row]);
        check("rd_o", rd_o, tab_rd[row]);
        check("rs1_o", rs1_o, tab_rs1[row]);
        check("rs2_o", rs2_o, tab_rs2[row]);
        check("imm_o", imm_o, tab_imm[row]);
        check("jump_o", jump_o, tab_jump[row]);
        check("reg_req_o", reg_req_o, expected_req(row));
      end
    end
  end

  `include "rv64_decoder_vectors.svh"

endmodule

`default_nettype wire

// ==== rv64_decoder_top.sv ====
// Two-stage RV64IM decoder, fixed latency of two cycles from valid_i to valid_o
// Chains the opcode match stage into the operand extract stage

`timescale 1ns/1ps
`default_nettype none

module rv64_decoder_top (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  valid_i,
  input  logic [rv64_decode_pkg::ILEN-1:0]      instr_i,
  output logic                                  valid_o,
  output rv64_decode_pkg::func_t                func_o,
  output logic [rv64_decode_pkg::REG_AW-1:0]    rd_o,
  output logic [rv64_decode_pkg::REG_AW-1:0]    rs1_o,
  output logic [rv64_decode_pkg::REG_AW-1:0]    rs2_o,
  output logic [rv64_decode_pkg::XLEN-1:0]      imm_o,
  output logic                                  jump_o,
  output logic [rv64_decode_pkg::NUM_REGS-1:0]  reg_req_o
);

  import rv64_decode_pkg::*;

  // Stage one to stage two
  logic     s1_valid;
  instr_u   s1_instr;
  func_t    s1_func;
  imm_fmt_t s1_fmt;
  logic     s1_use_rd;
  logic     s1_use_rs1;
  logic     s1_use_rs2;
  logic     s1_jump;

  rv64_opcode_match u_match (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .valid_i      (valid_i),
    .instr_i      (instr_i),
    .s1_valid_o   (s1_valid),
    .s1_instr_o   (s1_instr),
    .s1_func_o    (s1_func),
    .s1_fmt_o     (s1_fmt),
    .s1_use_rd_o  (s1_use_rd),
    .s1_use_rs1_o (s1_use_rs1),
    .s1_use_rs2_o (s1_use_rs2),
    .s1_jump_o    (s1_jump)
  );

  rv64_operand_extract u_extract (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .s1_valid_i   (s1_valid),
    .s1_instr_i   (s1_instr),
    .s1_func_i    (s1_func),
    .s1_fmt_i     (s1_fmt),
    .s1_use_rd_i  (s1_use_rd),
    .s1_use_rs1_i (s1_use_rs1),
    .s1_use_rs2_i (s1_use_rs2),
    .s1_jump_i    (s1_jump),
    .valid_o      (valid_o),
    .func_o       (func_o),
    .rd_o         (rd_o),
    .rs1_o        (rs1_o),
    .rs2_o        (rs2_o),
    .imm_o        (imm_o),
    .jump_o       (jump_o),
    .reg_req_o    (reg_req_o)
  );

endmodule

`default_nettype wire

// ==== rv64_operand_extract.sv ====
// Decode stage two: builds the immediate, register indices and reg_req vector
// Takes the stage one flags and registers the final decode

`timescale 1ns/1ps
`default_nettype none

module rv64_operand_extract (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  s1_valid_i,
  input  rv64_decode_pkg::instr_u               s1_instr_i,
  input  rv64_decode_pkg::func_t                s1_func_i,
  input  rv64_decode_pkg::imm_fmt_t             s1_fmt_i,
  input  logic                                  s1_use_rd_i,
  input  logic                                  s1_use_rs1_i,
  input  logic                                  s1_use_rs2_i,
  input  logic                                  s1_jump_i,
  output logic                                  valid_o,
  output rv64_decode_pkg::func_t                func_o,
  output logic [rv64_decode_pkg::REG_AW-1:0]    rd_o,
  output logic [rv64_decode_pkg::REG_AW-1:0]    rs1_o,
  output logic [rv64_decode_pkg::REG_AW-1:0]    rs2_o,
  output logic [rv64_decode_pkg::XLEN-1:0]      imm_o,
  output logic                                  jump_o,
  output logic [rv64_decode_pkg::NUM_REGS-1:0]  reg_req_o
);

  import rv64_decode_pkg::*;

  logic [11:0]       imm12;  // Bits 31..20
  logic              sgn;    // Instruction bit 31
  logic [XLEN-1:0]   imm_d;
  logic [REG_AW-1:0] rd_d;
  logic [REG_AW-1:0] rs1_d;
  logic [REG_AW-1:0] rs2_d;
  logic [NUM_REGS-1:0] reg_req_d;

  assign imm12 = s1_instr_i.i.imm12;
  assign sgn   = imm12[11];

  ////////////////////
  // Immediate
  ////////////////////

  always_comb begin
    case (s1_fmt_i)
      IMM_I: imm_d = {{(XLEN-12){sgn}}, imm12};
      IMM_S: imm_d = {{(XLEN-12){sgn}}, imm12[11:5], s1_instr_i.i.rd};
      IMM_B: imm_d = {{(XLEN-13){sgn}}, sgn, s1_instr_i.i.rd[0], imm12[10:5],
                      s1_instr_i.i.rd[4:1], 1'b0};
      IMM_U: imm_d = {{(XLEN-32){sgn}}, imm12, s1_instr_i.i.rs1,
                      s1_instr_i.i.funct3, 12'h000};
      IMM_J: imm_d = {{(XLEN-21){sgn}}, sgn, s1_instr_i.i.rs1, s1_instr_i.i.funct3,
                      imm12[0], imm12[10:1], 1'b0};
      IMM_SHAMT: imm_d = {{(XLEN-6){1'b0}}, imm12[5:0]};  // Always unsigned
      default: imm_d = '0;
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  assign rd_d  = s1_use_rd_i  ? s1_instr_i.r.rd  : '0;
  assign rs1_d = s1_use_rs1_i ? s1_instr_i.r.rs1 : '0;
  assign rs2_d = s1_use_rs2_i ? s1_instr_i.r.rs2 : '0;

  // Control transfers claim the whole file, others only what they name
  always_comb begin
    reg_req_d = '0;
    if (s1_jump_i) begin
      reg_req_d = '1;
    end else begin
      if (s1_use_rd_i) reg_req_d[rd_d] = 1'b1;
      if (s1_use_rs1_i) reg_req_d[rs1_d] = 1'b1;
      if (s1_use_rs2_i) reg_req_d[rs2_d] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o   <= 1'b0;
      func_o    <= F_ILLEGAL;
      rd_o      <= '0;
      rs1_o     <= '0;
      rs2_o     <= '0;
      imm_o     <= '0;
      jump_o    <= 1'b0;
      reg_req_o <= '0;
    end else begin
      valid_o <= s1_valid_i;
      if (s1_valid_i) begin
        func_o    <= s1_func_i;
        rd_o      <= rd_d;
        rs1_o     <= rs1_d;
        rs2_o     <= rs2_d;
        imm_o     <= imm_d;
        jump_o    <= s1_jump_i;
        reg_req_o <= reg_req_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rv64_opcode_match.sv ====
// Decode stage one: matches the word against the RV64IM table
// Registers function, immediate format, register use and jump alongside the word

`timescale 1ns/1ps
`default_nettype none

module rv64_opcode_match (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  rv64_decode_pkg::instr_u    instr_i,
  output logic                       s1_valid_o,
  output rv64_decode_pkg::instr_u    s1_instr_o,
  output rv64_decode_pkg::func_t     s1_func_o,
  output rv64_decode_pkg::imm_fmt_t  s1_fmt_o,
  output logic                       s1_use_rd_o,
  output logic                       s1_use_rs1_o,
  output logic                       s1_use_rs2_o,
  output logic                       s1_jump_o
);

  import rv64_decode_pkg::*;

  func_t    func_d;
  imm_fmt_t fmt_d;
  logic     use_rd_d;
  logic     use_rs1_d;
  logic     use_rs2_d;
  logic     jump_d;
  logic     sys_clear;  // rs1, funct3 and rd all zero

  assign sys_clear = (instr_i.i.rs1 == '0) && (instr_i.i.funct3 == 3'b000) &&
                     (instr_i.i.rd == '0);

  ////////////////////
  // Table match
  ////////////////////

  always_comb begin
    func_d    = F_ILLEGAL;
    fmt_d     = IMM_NONE;
    use_rd_d  = 1'b0;
    use_rs1_d = 1'b0;
    use_rs2_d = 1'b0;
    jump_d    = 1'b0;

    case (instr_i.r.opcode)
      OP_LUI: begin
        func_d   = F_LUI;
        fmt_d    = IMM_U;
        use_rd_d = 1'b1;
      end
      OP_AUIPC: begin
        func_d   = F_AUIPC;
        fmt_d    = IMM_U;
        use_rd_d = 1'b1;
      end
      OP_JAL: begin
        func_d   = F_JAL;
        fmt_d    = IMM_J;
        use_rd_d = 1'b1;
        jump_d   = 1'b1;
      end
      OP_JALR: begin
        if (instr_i.i.funct3 == 3'b000) func_d = F_JALR;
        fmt_d     = IMM_I;
        use_rd_d  = 1'b1;
        use_rs1_d = 1'b1;
        jump_d    = 1'b1;
      end
      OP_BRANCH: begin
        fmt_d     = IMM_B;
        use_rs1_d = 1'b1;
        use_rs2_d = 1'b1;
        jump_d    = 1'b1;
        case (instr_i.r.funct3)
          3'b000:  func_d = F_BEQ;
          3'b001:  func_d = F_BNE;
          3'b100:  func_d = F_BLT;
          3'b101:  func_d = F_BGE;
          3'b110:  func_d = F_BLTU;
          3'b111:  func_d = F_BGEU;
          default: func_d = F_ILLEGAL;
        endcase
      end
      OP_LOAD: begin
        fmt_d     = IMM_I;
        use_rd_d  = 1'b1;
        use_rs1_d = 1'b1;
        case (instr_i.i.funct3)
          3'b000:  func_d = F_LB;
          3'b001:  func_d = F_LH;
          3'b010:  func_d = F_LW;
          3'b011:  func_d = F_LD;
          3'b100:  func_d = F_LBU;
          3'b101:  func_d = F_LHU;
          3'b110:  func_d = F_LWU;
          default: func_d = F_ILLEGAL;
        endcase
      end
      OP_STORE: begin
        fmt_d     = IMM_S;
        use_rs1_d = 1'b1;
        use_rs2_d = 1'b1;
        case (instr_i.r.funct3)
          3'b000:  func_d = F_SB;
          3'b001:  func_d = F_SH;
          3'b010:  func_d = F_SW;
          3'b011:  func_d = F_SD;
          default: func_d = F_ILLEGAL;
        endcase
      end
      OP_IMM: begin
        fmt_d     = IMM_I;
        use_rd_d  = 1'b1;
        use_rs1_d = 1'b1;
        case (instr_i.i.funct3)
          3'b000: func_d = F_ADDI;
          3'b010: func_d = F_SLTI;
          3'b011: func_d = F_SLTIU;
          3'b100: func_d = F_XORI;
          3'b110: func_d = F_ORI;
          3'b111: func_d = F_ANDI;
          3'b001: begin
            fmt_d = IMM_SHAMT;
            if (instr_i.i.imm12[11:6] == FUNCT6_BASE) func_d = F_SLLI;
          end
          default: begin  // 3'b101, right shifts
            fmt_d = IMM_SHAMT;
            if (instr_i.i.imm12[11:6] == FUNCT6_BASE) func_d = F_SRLI;
            if (instr_i.i.imm12[11:6] == FUNCT6_ALT) func_d = F_SRAI;
          end
        endcase
      end
      OP_IMM_32: begin
        use_rd_d  = 1'b1;
        use_rs1_d = 1'b1;
        fmt_d     = (instr_i.i.funct3 == 3'b000) ? IMM_I : IMM_SHAMT;
        case ({instr_i.i.funct3, instr_i.i.imm12[11:5]})
          {3'b001, FUNCT7_BASE}: func_d = F_SLLIW;
          {3'b101, FUNCT7_BASE}: func_d = F_SRLIW;
          {3'b101, FUNCT7_ALT}:  func_d = F_SRAIW;
          default: if (instr_i.i.funct3 == 3'b000) func_d = F_ADDIW;
        endcase
      end
      OP_REG: begin
        use_rd_d  = 1'b1;
        use_rs1_d = 1'b1;
        use_rs2_d = 1'b1;
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {FUNCT7_BASE, 3'b000}:   func_d = F_ADD;
          {FUNCT7_BASE, 3'b001}:   func_d = F_SLL;
          {FUNCT7_BASE, 3'b010}:   func_d = F_SLT;
          {FUNCT7_BASE, 3'b011}:   func_d = F_SLTU;
          {FUNCT7_BASE, 3'b100}:   func_d = F_XOR;
          {FUNCT7_BASE, 3'b101}:   func_d = F_SRL;
          {FUNCT7_BASE, 3'b110}:   func_d = F_OR;
          {FUNCT7_BASE, 3'b111}:   func_d = F_AND;
          {FUNCT7_ALT, 3'b000}:    func_d = F_SUB;
          {FUNCT7_ALT, 3'b101}:    func_d = F_SRA;
          {FUNCT7_MULDIV, 3'b000}: func_d = F_MUL;
          {FUNCT7_MULDIV, 3'b001}: func_d = F_MULH;
          {FUNCT7_MULDIV, 3'b010}: func_d = F_MULHSU;
          {FUNCT7_MULDIV, 3'b011}: func_d = F_MULHU;
          {FUNCT7_MULDIV, 3'b100}: func_d = F_DIV;
          {FUNCT7_MULDIV, 3'b101}: func_d = F_DIVU;
          {FUNCT7_MULDIV, 3'b110}: func_d = F_REM;
          {FUNCT7_MULDIV, 3'b111}: func_d = F_REMU;
          default:                 func_d = F_ILLEGAL;
        endcase
      end
      OP_REG_32: begin
        use_rd_d  = 1'b1;
        use_rs1_d = 1'b1;
        use_rs2_d = 1'b1;
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {FUNCT7_BASE, 3'b000}:   func_d = F_ADDW;
          {FUNCT7_BASE, 3'b001}:   func_d = F_SLLW;
          {FUNCT7_BASE, 3'b101}:   func_d = F_SRLW;
          {FUNCT7_ALT, 3'b000}:    func_d = F_SUBW;
          {FUNCT7_ALT, 3'b101}:    func_d = F_SRAW;
          {FUNCT7_MULDIV, 3'b000}: func_d = F_MULW;
          {FUNCT7_MULDIV, 3'b100}: func_d = F_DIVW;
          {FUNCT7_MULDIV, 3'b101}: func_d = F_DIVUW;
          {FUNCT7_MULDIV, 3'b110}: func_d = F_REMW;
          {FUNCT7_MULDIV, 3'b111}: func_d = F_REMUW;
          default:                 func_d = F_ILLEGAL;
        endcase
      end
      OP_MISC_MEM: begin
        // pred/succ travel in the I immediate
        fmt_d     = IMM_I;
        use_rd_d  = 1'b1;
        use_rs1_d = 1'b1;
        if (instr_i.i.funct3 == 3'b000 && instr_i != FENCE_TSO_WORD &&
            instr_i != PAUSE_WORD) begin
          func_d = F_FENCE;
        end
      end
      OP_SYSTEM: begin
        // Only the two exact words, CSR space is dropped
        if (sys_clear && instr_i.i.imm12 == ECALL_WORD[31:20]) func_d = F_ECALL;
        if (sys_clear && instr_i.i.imm12 == EBREAK_WORD[31:20]) func_d = F_EBREAK;
      end
      default: func_d = F_ILLEGAL;
    endcase

    // Illegal words carry nothing downstream
    if (func_d == F_ILLEGAL) begin
      fmt_d     = IMM_NONE;
      use_rd_d  = 1'b0;
      use_rs1_d = 1'b0;
      use_rs2_d = 1'b0;
      jump_d    = 1'b0;
    end
  end

  ////////////////////
  // Stage register
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_o   <= 1'b0;
      s1_instr_o   <= '0;
      s1_func_o    <= F_ILLEGAL;
      s1_fmt_o     <= IMM_NONE;
      s1_use_rd_o  <= 1'b0;
      s1_use_rs1_o <= 1'b0;
      s1_use_rs2_o <= 1'b0;
      s1_jump_o    <= 1'b0;
    end else begin
      s1_valid_o <= valid_i;
      if (valid_i) begin  // Hold last decode otherwise
        s1_instr_o   <= instr_i;
        s1_func_o    <= func_d;
        s1_fmt_o     <= fmt_d;
        s1_use_rd_o  <= use_rd_d;
        s1_use_rs1_o <= use_rs1_d;
        s1_use_rs2_o <= use_rs2_d;
        s1_jump_o    <= jump_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rv64_decode_pkg.sv ====
// Shared widths, encodings and instruction layout for the pipelined RV64IM decoder
// Imported by both decode stages and the top level

`default_nettype none

package rv64_decode_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int ILEN     = 32;  // Instruction word
  localparam int XLEN     = 64;  // Immediate and data
  localparam int REG_AW   = 5;   // Register index
  localparam int NUM_REGS = 32;  // Integer register file, also reg_req width

  ////////////////////
  // Decoded functions
  ////////////////////

  // Zero is reserved for anything outside the kept instruction set
  typedef enum logic [7:0] {
    F_ILLEGAL = 8'd0,
    // Upper immediate and control transfer
    F_LUI,
    F_AUIPC,
    F_JAL,
    F_JALR,
    F_BEQ,
    F_BNE,
    F_BLT,
    F_BGE,
    F_BLTU,
    F_BGEU,
    // Loads and stores
    F_LB,
    F_LH,
    F_LW,
    F_LD,
    F_LBU,
    F_LHU,
    F_LWU,
    F_SB,
    F_SH,
    F_SW,
    F_SD,
    // Register-immediate ALU
    F_ADDI,
    F_SLTI,
    F_SLTIU,
    F_XORI,
    F_ORI,
    F_ANDI,
    F_SLLI,
    F_SRLI,
    F_SRAI,
    // Register-register ALU
    F_ADD,
    F_SUB,
    F_SLL,
    F_SLT,
    F_SLTU,
    F_XOR,
    F_SRL,
    F_SRA,
    F_OR,
    F_AND,
    // 32-bit word forms
    F_ADDIW,
    F_SLLIW,
    F_SRLIW,
    F_SRAIW,
    F_ADDW,
    F_SUBW,
    F_SLLW,
    F_SRLW,
    F_SRAW,
    // Memory ordering and environment
    F_FENCE,
    F_ECALL,
    F_EBREAK,
    // M extension
    F_MUL,
    F_MULH,
    F_MULHSU,
    F_MULHU,
    F_DIV,
    F_DIVU,
    F_REM,
    F_REMU,
    F_MULW,
    F_DIVW,
    F_DIVUW,
    F_REMW,
    F_REMUW
  } func_t;

  // Immediate layout carried by the instruction
  typedef enum logic [2:0] {
    IMM_NONE  = 3'd0,
    IMM_I     = 3'd1,
    IMM_S     = 3'd2,
    IMM_B     = 3'd3,
    IMM_U     = 3'd4,
    IMM_J     = 3'd5,
    IMM_SHAMT = 3'd6
  } imm_fmt_t;

  ////////////////////
  // Encodings
  ////////////////////

  localparam logic [6:0] OP_LUI      = 7'b0110111;
  localparam logic [6:0] OP_AUIPC    = 7'b0010111;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_LOAD     = 7'b0000011;
  localparam logic [6:0] OP_STORE    = 7'b0100011;
  localparam logic [6:0] OP_IMM      = 7'b0010011;
  localparam logic [6:0] OP_IMM_32   = 7'b0011011;
  localparam logic [6:0] OP_REG      = 7'b0110011;
  localparam logic [6:0] OP_REG_32   = 7'b0111011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM   = 7'b1110011;

  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // SUB, SRA and friends
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // RV64 shift-immediates give bit 25 to shamt
  localparam logic [5:0] FUNCT6_BASE = 6'b000000;
  localparam logic [5:0] FUNCT6_ALT  = 6'b010000;

  localparam logic [31:0] ECALL_WORD     = 32'h0000_0073;
  localparam logic [31:0] EBREAK_WORD    = 32'h0010_0073;
  localparam logic [31:0] FENCE_TSO_WORD = 32'h8330_000F;  // Not supported
  localparam logic [31:0] PAUSE_WORD     = 32'h0100_000F;  // Not supported

  ////////////////////
  // Instruction word
  ////////////////////

  // Same 32 bits seen as R-type fields or as I-type fields
  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r;
    struct packed {
      logic [11:0]       imm12;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i;
  } instr_u;

endpackage

`default_nettype wire
